// ==== dv/tb_saturn_tasks.svh ====
// longest field is 16 nibbles plus one spare pass
localparam int PASS_LIMIT = 17;

function automatic nibble_t nib_of(word_t w, int k);
  return w[k*4 +: 4];
endfunction

function automatic word_t with_nib(word_t w, int k, nibble_t n);
  word_t r;
  r = w;
  r[k*4 +: 4] = n;
  return r;
endfunction

// field may wrap past nibble 15
function automatic bit in_field(int k, field_ptr_t fs, field_ptr_t fl);
  if (fs <= fl) begin
    return (k >= fs) && (k <= fl);
  end
  return (k >= fs) || (k <= fl);
endfunction

function automatic word_t field_value(word_t w, int lo, int cnt);
  word_t mask;
  mask = (64'd1 << (cnt * 4)) - 64'd1;
  return (w >> (lo * 4)) & mask;
endfunction

// two's complement modulo 16**cnt of the field with the rest untouched
function automatic word_t negate_field(word_t w, int lo, int cnt);
  word_t mask;
  word_t neg;
  mask = (64'd1 << (cnt * 4)) - 64'd1;
  neg  = ((~field_value(w, lo, cnt)) + 64'd1) & mask;
  return (w & ~(mask << (lo * 4))) | (neg << (lo * 4));
endfunction

task automatic compare_word(input string name, input word_t got, input word_t exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic compare_nibble(input string name, input nibble_t got, input nibble_t exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic report_test(input string name, input int errs_before);
  test_count++;
  $display("%s finished with %0d errors", name, err_count - errs_before);
endtask

// called on a falling edge and returns on the next one
task automatic pulse_phase(input int phase);
  i_en_alu_prep = (phase == 0);
  i_en_alu_calc = (phase == 1);
  i_en_alu_save = (phase == 2);
  @(negedge i_clk);
  i_en_alu_prep = 1'b0;
  i_en_alu_calc = 1'b0;
  i_en_alu_save = 1'b0;
endtask

// init strobe then prep/calc/save passes until the stall drops
task automatic run_op(input alu_op_t op, input reg_sel_t dest, input reg_sel_t src1,
                      input reg_sel_t src2, input field_ptr_t fs, input field_ptr_t fl,
                      input nibble_t imm, input logic push);
  int passes;
  @(negedge i_clk);
  i_alu_op      = op;
  i_reg_dest    = dest;
  i_reg_src1    = src1;
  i_reg_src2    = src2;
  i_field_start = fs;
  i_field_last  = fl;
  i_imm_value   = imm;
  i_push        = push;
  i_en_alu_init = 1'b1;
  i_ins_alu_op  = 1'b1;
  @(negedge i_clk);
  i_en_alu_init = 1'b0;
  i_ins_alu_op  = 1'b0;
  passes = 0;
  while (o_alu_stall_dec && passes < PASS_LIMIT) begin
    pulse_phase(0);
    pulse_phase(1);
    pulse_phase(2);
    passes++;
  end
  i_push = 1'b0;
  if (o_alu_stall_dec) begin
    $display("timeout: stall still high after %0d passes of %s", passes, op.name());
    err_count++;
    finish_run();
  end
endtask

// save strobe while idle for mode, RTN and pop
task automatic control_save(input logic set_mode, input logic mode_dec, input logic rtn,
                            input logic set_xm, input logic set_carry,
                            input logic carry_val, input logic pop);
  @(negedge i_clk);
  i_ins_set_mode = set_mode;
  i_mode_dec     = mode_dec;
  i_ins_rtn      = rtn;
  i_set_xm       = set_xm;
  i_set_carry    = set_carry;
  i_carry_val    = carry_val;
  i_pop          = pop;
  pulse_phase(2);
  i_ins_set_mode = 1'b0;
  i_ins_rtn      = 1'b0;
  i_set_xm       = 1'b0;
  i_set_carry    = 1'b0;
  i_carry_val    = 1'b0;
  i_pop          = 1'b0;
endtask

task automatic read_back(input reg_sel_t sel, input word_t exp, input string name);
  @(negedge i_clk);
  i_rd_sel = sel;
  #10;
  compare_word($sformatf("o_rd_data %s", name), o_rd_data, exp);
endtask

// one single-nibble copy per digit
task automatic load_word(input reg_sel_t dest, input word_t value);
  for (int k = 0; k < 16; k++) begin
    run_op(OP_COPY, dest, REG_IMM, REG_A, field_ptr_t'(k), field_ptr_t'(k),
           nib_of(value, k), 1'b0);
  end
endtask

task automatic check_reset_state();
  int errs;
  errs = err_count;
  compare_addr("o_pc", o_pc, 20'hFFFFF);
  compare_bit("o_alu_stall_dec", o_alu_stall_dec, 1'b0);
  compare_bit("o_carry", o_carry, 1'b0);
  compare_bit("o_mode_dec", o_mode_dec, 1'b0);
  read_back(REG_A, '0, "A after reset");
  report_test("check_reset_state", errs);
endtask

task automatic field_ops();
  int      errs;
  nibble_t imm_a;
  nibble_t imm_b;
  nibble_t t;
  word_t   exp_a;
  word_t   exp_b;
  errs  = err_count;
  // shared top bit keeps copy, clear-mask and exchange visible
  imm_a = nibble_t'($urandom) | 4'h8;
  imm_b = nibble_t'($urandom) | 4'h8;
  exp_a = '0;
  exp_b = '0;
  run_op(OP_COPY, REG_A, REG_IMM, REG_A, 4'd0, 4'd15, imm_a, 1'b0);
  for (int k = 0; k < 16; k++) begin
    exp_a = with_nib(exp_a, k, imm_a);
  end
  read_back(REG_A, exp_a, "A after copy");
  run_op(OP_COPY, REG_B, REG_IMM, REG_A, 4'd4, 4'd11, imm_b, 1'b0);
  for (int k = 0; k < 16; k++) begin
    if (in_field(k, 4'd4, 4'd11)) begin
      exp_b = with_nib(exp_b, k, imm_b);
    end
  end
  read_back(REG_B, exp_b, "B after copy");
  run_op(OP_CLR_MASK, REG_A, REG_A, REG_B, 4'd2, 4'd9, 4'h0, 1'b0);
  for (int k = 0; k < 16; k++) begin
    if (in_field(k, 4'd2, 4'd9)) begin
      exp_a = with_nib(exp_a, k, nib_of(exp_a, k) & ~nib_of(exp_b, k));
    end
  end
  read_back(REG_A, exp_a, "A after clear-mask");
  // field wraps through nibble 15 back to 1
  run_op(OP_ZERO, REG_A, REG_A, REG_A, 4'd14, 4'd1, 4'h0, 1'b0);
  for (int k = 0; k < 16; k++) begin
    if (in_field(k, 4'd14, 4'd1)) begin
      exp_a = with_nib(exp_a, k, 4'h0);
    end
  end
  read_back(REG_A, exp_a, "A after zero");
  run_op(OP_EXCH, REG_A, REG_A, REG_B, 4'd6, 4'd14, 4'h0, 1'b0);
  for (int k = 0; k < 16; k++) begin
    if (in_field(k, 4'd6, 4'd14)) begin
      t     = nib_of(exp_a, k);
      exp_a = with_nib(exp_a, k, nib_of(exp_b, k));
      exp_b = with_nib(exp_b, k, t);
    end
  end
  read_back(REG_A, exp_a, "A after exchange");
  read_back(REG_B, exp_b, "B after exchange");
  report_test("field_ops", errs);
endtask

task automatic twos_complement();
  int    errs;
  word_t c_val;
  word_t exp_c;
  errs  = err_count;
  c_val = 64'hFEDC_BA98_7654_3210;
  load_word(REG_C, c_val);
  read_back(REG_C, c_val, "C after load");
  // nibbles 4..9 hold a nonzero field
  exp_c = negate_field(c_val, 4, 6);
  run_op(OP_2CMPL, REG_C, REG_C, REG_A, 4'd4, 4'd9, 4'h0, 1'b0);
  read_back(REG_C, exp_c, "C after 2cmpl 4..9");
  compare_bit("o_carry", o_carry, field_value(c_val, 4, 6) != 0);
  // nibble 0 holds zero
  exp_c = negate_field(exp_c, 0, 1);
  run_op(OP_2CMPL, REG_C, REG_C, REG_A, 4'd0, 4'd0, 4'h0, 1'b0);
  read_back(REG_C, exp_c, "C after 2cmpl 0..0");
  compare_bit("o_carry", o_carry, 1'b0);
  report_test("twos_complement", errs);
endtask

task automatic p_and_st_bits();
  int      errs;
  nibble_t p_val;
  nibble_t bit_a;
  nibble_t bit_b;
  st_t     exp_st;
  errs   = err_count;
  // nonzero so the copy differs from the reset value of P
  p_val  = nibble_t'($urandom % 15) + 4'h1;
  bit_a  = nibble_t'($urandom);
  bit_b  = bit_a ^ 4'h9;
  exp_st = '0;
  run_op(OP_COPY, REG_P, REG_IMM, REG_A, 4'd0, 4'd0, p_val, 1'b0);
  compare_nibble("o_reg_p", o_reg_p, p_val);
  run_op(OP_SET_BIT, REG_ST, REG_IMM, REG_A, 4'd0, 4'd0, bit_a, 1'b0);
  exp_st[bit_a] = 1'b1;
  run_op(OP_SET_BIT, REG_ST, REG_IMM, REG_A, 4'd0, 4'd0, bit_b, 1'b0);
  exp_st[bit_b] = 1'b1;
  read_back(REG_ST, word_t'(exp_st), "ST after set-bit");
  run_op(OP_RST_BIT, REG_ST, REG_IMM, REG_A, 4'd0, 4'd0, bit_a, 1'b0);
  exp_st[bit_a] = 1'b0;
  read_back(REG_ST, word_t'(exp_st), "ST after reset-bit");
  report_test("p_and_st_bits", errs);
endtask

task automatic mode_and_rtn();
  int errs;
  errs = err_count;
  control_save(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  compare_bit("o_mode_dec after SETDEC", o_mode_dec, 1'b1);
  control_save(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  compare_bit("o_mode_dec after SETHEX", o_mode_dec, 1'b0);
  control_save(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
  compare_bit("o_carry after RTN", o_carry, 1'b1);
  read_back(REG_HST, word_t'(1) << HST_XM, "HST after RTN");
  report_test("mode_and_rtn", errs);
endtask

task automatic pc_jumps();
  int    errs;
  word_t c_val;
  addr_t pre_pc;
  addr_t exp_pc;
  errs  = err_count;
  c_val = 64'h0123_4567_89AB_CDEF;
  load_word(REG_C, c_val);
  run_op(OP_JMP_ABS5, REG_A, REG_C, REG_A, 4'd0, 4'd4, 4'h0, 1'b0);
  compare_addr("o_pc after ABS5", o_pc, c_val[19:0]);
  pre_pc = o_pc;
  run_op(OP_JMP_REL3, REG_A, REG_C, REG_A, 4'd0, 4'd2, 4'h0, 1'b1);
  exp_pc = pre_pc + {{8{c_val[11]}}, c_val[11:0]};
  compare_addr("o_pc after REL3", o_pc, exp_pc);
  // two earlier digit saves stepped the PC before the push
  control_save(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
  compare_addr("o_pc after pop", o_pc, pre_pc + 20'd2);
  report_test("pc_jumps", errs);
endtask

// ==== dv/tb_saturn_alu.sv ====
`timescale 1ns/1ps

module tb_saturn_alu
  import saturn_regs_pkg::*, saturn_alu_pkg::*;
();

  logic       i_clk;
  logic       i_reset;
  logic       i_en_alu_init;
  logic       i_en_alu_prep;
  logic       i_en_alu_calc;
  logic       i_en_alu_save;
  logic       i_ins_alu_op;
  alu_op_t    i_alu_op;
  logic       i_alu_no_stall;
  reg_sel_t   i_reg_dest;
  reg_sel_t   i_reg_src1;
  reg_sel_t   i_reg_src2;
  field_ptr_t i_field_start;
  field_ptr_t i_field_last;
  nibble_t    i_imm_value;
  logic       i_push;
  logic       i_pop;
  logic       i_ins_rtn;
  logic       i_set_xm;
  logic       i_set_carry;
  logic       i_carry_val;
  logic       i_ins_set_mode;
  logic       i_mode_dec;
  reg_sel_t   i_rd_sel;
  logic       o_alu_stall_dec;
  nibble_t    o_reg_p;
  addr_t      o_pc;
  logic       o_carry;
  logic       o_mode_dec;
  word_t      o_rd_data;

  int test_count;
  int check_count;
  int err_count;

  saturn_alu #(
    .RSTK_DEPTH (8)
  ) u_saturn_alu (.*);

  `include "tb_saturn_tasks.svh"

  // closing summary and end of the run
  task automatic finish_run();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  initial begin
    void'($urandom(82885));
    test_count     = 0;
    check_count    = 0;
    err_count      = 0;
    i_reset        = 1'b1;
    i_en_alu_init  = 1'b0;
    i_en_alu_prep  = 1'b0;
    i_en_alu_calc  = 1'b0;
    i_en_alu_save  = 1'b0;
    i_ins_alu_op   = 1'b0;
    i_alu_op       = OP_ZERO;
    i_alu_no_stall = 1'b0;
    i_reg_dest     = REG_A;
    i_reg_src1     = REG_A;
    i_reg_src2     = REG_A;
    i_field_start  = '0;
    i_field_last   = '0;
    i_imm_value    = '0;
    i_push         = 1'b0;
    i_pop          = 1'b0;
    i_ins_rtn      = 1'b0;
    i_set_xm       = 1'b0;
    i_set_carry    = 1'b0;
    i_carry_val    = 1'b0;
    i_ins_set_mode = 1'b0;
    i_mode_dec     = 1'b0;
    i_rd_sel       = REG_A;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;

    check_reset_state();
    field_ops();
    twos_complement();
    p_and_st_bits();
    mode_and_rtn();
    pc_jumps();
    finish_run();
  end

endmodule

// ==== hdl/alu_nibble_calc.sv ====
`timescale 1ns/1ps

module alu_nibble_calc
  import saturn_regs_pkg::*, saturn_alu_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_prep_go,
  input  logic       i_calc_go,
  input  alu_op_t    i_op,
  input  logic       i_first,
  input  logic       i_last,
  input  field_ptr_t i_f_cur,
  input  nibble_t    i_src1_nib,
  input  nibble_t    i_src2_nib,
  output nibble_t    o_res1,
  output nibble_t    o_res2,
  output logic       o_nonzero,
  output addr_t      o_jump_off
);

  nibble_t    p_src1;
  nibble_t    p_src2;
  logic       p_carry;
  logic       c_carry;
  logic [4:0] neg_sum;
  logic [5:0] off_sh;
  addr_t      off_nxt;

  // inverted digit plus incoming carry, bit 4 is the carry out
  assign neg_sum = {1'b0, ~p_src1} + {4'b0000, p_carry};
  assign off_sh  = {i_f_cur, 2'b00};

  // slot the current digit into the offset, sign extend on the top digit
  always_comb begin
    off_nxt = i_first ? '0 : o_jump_off;
    off_nxt = (off_nxt & ~(addr_t'(4'hF) << off_sh)) | (addr_t'(p_src1) << off_sh);
    if (i_last && i_op == OP_JMP_REL3) begin
      off_nxt[19:12] = {8{p_src1[3]}};
    end
    if (i_last && i_op == OP_JMP_REL4) begin
      off_nxt[19:16] = {4{p_src1[3]}};
    end
  end

  // operand latches
  always_ff @(posedge i_clk) begin
    if (i_prep_go) begin
      p_src1 <= i_src1_nib;
      p_src2 <= i_src2_nib;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      p_carry    <= 1'b0;
      c_carry    <= 1'b0;
      o_nonzero  <= 1'b0;
      o_res1     <= '0;
      o_res2     <= '0;
      o_jump_off <= '0;
    end else begin
      if (i_prep_go && i_op == OP_2CMPL) begin
        p_carry <= i_first ? 1'b1 : c_carry;
      end
      if (i_calc_go) begin
        // restarts with every new field
        o_nonzero <= (o_nonzero && !i_first) || (p_src1 != 4'h0);
        case (i_op)
          OP_ZERO: o_res1 <= '0;
          OP_COPY, OP_SET_BIT, OP_RST_BIT: o_res1 <= p_src1;
          OP_EXCH: begin
            o_res1 <= p_src2;
            o_res2 <= p_src1;
          end
          OP_CLR_MASK: o_res1 <= p_src1 & ~p_src2;
          OP_2CMPL: begin
            o_res1  <= neg_sum[3:0];
            c_carry <= neg_sum[4];
          end
          OP_JMP_REL3, OP_JMP_REL4, OP_JMP_ABS5: o_jump_off <= off_nxt;
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== hdl/alu_pc_ctrl.sv ====
`timescale 1ns/1ps

module alu_pc_ctrl
  import saturn_regs_pkg::*, saturn_alu_pkg::*;
#(
  parameter int RSTK_DEPTH = 8
) (
  input  logic    i_clk,
  input  logic    i_reset,
  input  logic    i_en_alu_save,
  input  logic    i_prep_go,
  input  alu_op_t i_op,
  input  logic    i_first,
  input  logic    i_last,
  input  logic    i_is_jump,
  input  logic    i_stall,
  input  logic    i_push,
  input  logic    i_pop,
  input  addr_t   i_jump_off,
  output addr_t   o_pc
);

  localparam int PW = $clog2(RSTK_DEPTH);

  addr_t         jump_bse;
  addr_t         jump_pc;
  addr_t         next_pc;
  addr_t         rstk [RSTK_DEPTH];
  logic [PW:0]   rstk_cnt;
  logic [PW-1:0] top_idx;
  logic          update_pc;
  logic          push_pc;

  assign top_idx = rstk_cnt[PW-1:0] - PW'(1);

  assign jump_pc   = (i_op == OP_JMP_ABS5) ? i_jump_off : jump_bse + i_jump_off;
  assign next_pc   = (i_is_jump && i_last) ? jump_pc : o_pc + 20'd1;
  // jumps and returns move the PC even while the decoder is held
  assign update_pc = !i_stall || i_is_jump;
  assign push_pc   = update_pc && i_push && i_last;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_pc     <= '1;
      jump_bse <= '0;
      rstk_cnt <= '0;
    end else begin
      // base is the first offset digit, or the next instruction for a call
      if (i_prep_go && i_first) begin
        jump_bse <= i_push ? o_pc : o_pc - 20'd1;
      end
      if (i_en_alu_save) begin
        if (update_pc) begin
          o_pc <= i_pop ? rstk[top_idx] : next_pc;
        end
        if (i_pop) begin
          rstk_cnt <= rstk_cnt - 1'b1;
        end else if (push_pc) begin
          rstk_cnt <= rstk_cnt + 1'b1;
        end
      end
    end
  end

  // return stack storage
  always_ff @(posedge i_clk) begin
    if (!i_reset && i_en_alu_save && push_pc && !i_pop) begin
      rstk[rstk_cnt[PW-1:0]] <= o_pc;
    end
  end

  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_en_alu_save && i_pop) |-> (rstk_cnt != '0));

  a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_en_alu_save && push_pc && !i_pop) |-> (rstk_cnt < (PW+1)'(RSTK_DEPTH)));

endmodule

// ==== hdl/alu_regfile.sv ====
`timescale 1ns/1ps

module alu_regfile
  import saturn_regs_pkg::*, saturn_alu_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_save_go,
  input  alu_op_t    i_op,
  input  reg_sel_t   i_dest,
  input  reg_sel_t   i_src1,
  input  reg_sel_t   i_src2,
  input  field_ptr_t i_f_cur,
  input  logic       i_last,
  input  nibble_t    i_imm_value,
  input  nibble_t    i_res1,
  input  nibble_t    i_res2,
  input  logic       i_nonzero,
  input  logic       i_ins_rtn,
  input  logic       i_set_xm,
  input  logic       i_set_carry,
  input  logic       i_carry_val,
  input  logic       i_ins_set_mode,
  input  logic       i_en_alu_save,
  input  logic       i_mode_dec,
  input  reg_sel_t   i_rd_sel,
  output nibble_t    o_src1_nib,
  output nibble_t    o_src2_nib,
  output nibble_t    o_reg_p,
  output logic       o_carry,
  output logic       o_mode_dec,
  output word_t      o_rd_data
);

  word_t   reg_a;
  word_t   reg_b;
  word_t   reg_c;
  word_t   reg_d;
  addr_t   reg_d0;
  addr_t   reg_d1;
  st_t     reg_st;
  nibble_t reg_p;
  nibble_t reg_hst;
  word_t   reg_view [32];
  logic    wr_res1;
  logic    wr_res2;
  logic    wr_bit;

  function automatic nibble_t pick_nib(reg_sel_t sel, word_t w, field_ptr_t f);
    word_t sh;
    sh = w >> {f, 2'b00};
    // single-digit sources ignore the field pointer
    if (sel inside {REG_P, REG_HST, REG_IMM}) begin
      return w[3:0];
    end
    return sh[3:0];
  endfunction

  function automatic word_t put_nib(word_t w, field_ptr_t f, nibble_t n);
    logic [5:0] sh;
    sh = {f, 2'b00};
    return (w & ~(word_t'(4'hF) << sh)) | (word_t'(n) << sh);
  endfunction

  // applies both save ports to one multi-digit register
  function automatic word_t upd(word_t w, reg_sel_t me);
    word_t r;
    r = w;
    if (wr_res1 && i_dest == me) begin
      r = put_nib(r, i_f_cur, i_res1);
    end
    if (wr_res2 && i_src2 == me) begin
      r = put_nib(r, i_f_cur, i_res2);
    end
    return r;
  endfunction

  assign wr_res1 = i_save_go && (i_op inside {OP_ZERO, OP_COPY, OP_EXCH, OP_2CMPL, OP_CLR_MASK});
  assign wr_res2 = i_save_go && (i_op == OP_EXCH);
  assign wr_bit  = i_save_go && (i_op inside {OP_SET_BIT, OP_RST_BIT});

  // every register widened to a word, indexed by its select code
  always_comb begin
    for (int i = 0; i < 32; i++) begin
      reg_view[i] = '0;
    end
    reg_view[REG_A]   = reg_a;
    reg_view[REG_B]   = reg_b;
    reg_view[REG_C]   = reg_c;
    reg_view[REG_D]   = reg_d;
    reg_view[REG_D0]  = word_t'(reg_d0);
    reg_view[REG_D1]  = word_t'(reg_d1);
    reg_view[REG_ST]  = word_t'(reg_st);
    reg_view[REG_P]   = word_t'(reg_p);
    reg_view[REG_HST] = word_t'(reg_hst);
    reg_view[REG_IMM] = word_t'(i_imm_value);
  end

  assign o_src1_nib = pick_nib(i_src1, reg_view[i_src1], i_f_cur);
  assign o_src2_nib = pick_nib(i_src2, reg_view[i_src2], i_f_cur);
  assign o_rd_data  = reg_view[i_rd_sel];
  assign o_reg_p    = reg_p;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      reg_a      <= '0;
      reg_b      <= '0;
      reg_c      <= '0;
      reg_d      <= '0;
      reg_d0     <= '0;
      reg_d1     <= '0;
      reg_st     <= '0;
      reg_p      <= '0;
      reg_hst    <= '0;
      o_carry    <= 1'b0;
      o_mode_dec <= 1'b0;
    end else begin
      reg_a  <= upd(reg_a, REG_A);
      reg_b  <= upd(reg_b, REG_B);
      reg_c  <= upd(reg_c, REG_C);
      reg_d  <= upd(reg_d, REG_D);
      reg_d0 <= addr_t'(upd(word_t'(reg_d0), REG_D0));
      reg_d1 <= addr_t'(upd(word_t'(reg_d1), REG_D1));
      reg_st <= st_t'(upd(word_t'(reg_st), REG_ST));
      if (wr_res1 && i_dest == REG_P) begin
        reg_p <= i_res1;
      end
      if (wr_res2 && i_src2 == REG_P) begin
        reg_p <= i_res2;
      end
      if (wr_res1 && i_dest == REG_HST) begin
        reg_hst <= i_res1;
      end
      // res1 carries the bit number
      if (wr_bit && i_dest == REG_ST) begin
        reg_st[i_res1] <= (i_op == OP_SET_BIT);
      end
      if (i_save_go && i_last && i_op == OP_2CMPL) begin
        o_carry <= i_nonzero;
      end
      if (i_en_alu_save && i_ins_rtn) begin
        if (i_set_xm) begin
          reg_hst[HST_XM] <= 1'b1;
        end
        if (i_set_carry) begin
          o_carry <= i_carry_val;
        end
      end
      // SETHEX / SETDEC
      if (i_en_alu_save && i_ins_set_mode) begin
        o_mode_dec <= i_mode_dec;
      end
    end
  end

endmodule

// ==== hdl/alu_sequencer.sv ====
`timescale 1ns/1ps

module alu_sequencer
  import saturn_regs_pkg::*, saturn_alu_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_en_alu_init,
  input  logic       i_en_alu_prep,
  input  logic       i_en_alu_calc,
  input  logic       i_en_alu_save,
  input  logic       i_ins_alu_op,
  input  alu_op_t    i_alu_op,
  input  logic       i_alu_no_stall,
  input  reg_sel_t   i_reg_dest,
  input  reg_sel_t   i_reg_src1,
  input  reg_sel_t   i_reg_src2,
  input  field_ptr_t i_field_start,
  input  field_ptr_t i_field_last,
  input  logic       i_ins_rtn,
  output logic       o_run,
  output logic       o_prep_go,
  output logic       o_calc_go,
  output logic       o_save_go,
  output alu_op_t    o_op,
  output reg_sel_t   o_dest,
  output reg_sel_t   o_src1,
  output reg_sel_t   o_src2,
  output field_ptr_t o_f_cur,
  output logic       o_first,
  output logic       o_last,
  output logic       o_is_jump,
  output logic       o_stall
);

  field_ptr_t f_first;
  field_ptr_t f_last;
  logic       run;
  logic       done;
  logic       do_init;

  // a new instruction is only accepted while idle
  assign do_init   = i_en_alu_init && i_ins_alu_op && !run;
  assign o_prep_go = i_en_alu_prep && run;
  assign o_calc_go = i_en_alu_calc && run;
  assign o_save_go = i_en_alu_save && run;

  assign o_run   = run;
  assign o_first = (o_f_cur == f_first);
  assign o_last  = (o_f_cur == f_last);

  // decoder may run ahead, but never past the last nibble
  assign o_stall = run && (!i_alu_no_stall || o_last);

  assign o_is_jump = (o_op inside {OP_JMP_REL3, OP_JMP_REL4, OP_JMP_ABS5}) || i_ins_rtn;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      run     <= 1'b0;
      done    <= 1'b0;
      o_op    <= OP_ZERO;
      o_dest  <= REG_A;
      o_src1  <= REG_A;
      o_src2  <= REG_A;
      f_first <= '0;
      f_last  <= '0;
      o_f_cur <= '0;
    end else begin
      if (do_init) begin
        run     <= 1'b1;
        o_op    <= i_alu_op;
        o_dest  <= i_reg_dest;
        o_src1  <= i_reg_src1;
        o_src2  <= i_reg_src2;
        f_first <= i_field_start;
        f_last  <= i_field_last;
        o_f_cur <= i_field_start;
      end
      if (o_prep_go) begin
        done <= 1'b0;
      end
      if (o_calc_go) begin
        done <= o_last;
      end
      // pointer wraps from 15 back to 0
      if (o_save_go) begin
        o_f_cur <= o_f_cur + 4'd1;
        if (done) begin
          run  <= 1'b0;
          done <= 1'b0;
        end
      end
    end
  end

  a_one_phase: assert property (@(posedge i_clk) disable iff (i_reset)
    $onehot0({i_en_alu_init, i_en_alu_prep, i_en_alu_calc, i_en_alu_save}));

endmodule

// ==== hdl/saturn_alu.sv ====
`timescale 1ns/1ps

module saturn_alu
  import saturn_regs_pkg::*, saturn_alu_pkg::*;
#(
  parameter int RSTK_DEPTH = 8
) (
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_en_alu_init,
  input  logic       i_en_alu_prep,
  input  logic       i_en_alu_calc,
  input  logic       i_en_alu_save,
  input  logic       i_ins_alu_op,
  input  alu_op_t    i_alu_op,
  input  logic       i_alu_no_stall,
  input  reg_sel_t   i_reg_dest,
  input  reg_sel_t   i_reg_src1,
  input  reg_sel_t   i_reg_src2,
  input  field_ptr_t i_field_start,
  input  field_ptr_t i_field_last,
  input  nibble_t    i_imm_value,
  input  logic       i_push,
  input  logic       i_pop,
  input  logic       i_ins_rtn,
  input  logic       i_set_xm,
  input  logic       i_set_carry,
  input  logic       i_carry_val,
  input  logic       i_ins_set_mode,
  input  logic       i_mode_dec,
  input  reg_sel_t   i_rd_sel,
  output logic       o_alu_stall_dec,
  output nibble_t    o_reg_p,
  output addr_t      o_pc,
  output logic       o_carry,
  output logic       o_mode_dec,
  output word_t      o_rd_data
);

  alu_op_t    op;
  reg_sel_t   dest;
  reg_sel_t   src1;
  reg_sel_t   src2;
  field_ptr_t f_cur;
  logic       prep_go;
  logic       calc_go;
  logic       save_go;
  logic       first;
  logic       last;
  logic       is_jump;
  nibble_t    src1_nib;
  nibble_t    src2_nib;
  nibble_t    res1;
  nibble_t    res2;
  logic       nonzero;
  addr_t      jump_off;

  alu_sequencer u_sequencer (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_en_alu_init  (i_en_alu_init),
    .i_en_alu_prep  (i_en_alu_prep),
    .i_en_alu_calc  (i_en_alu_calc),
    .i_en_alu_save  (i_en_alu_save),
    .i_ins_alu_op   (i_ins_alu_op),
    .i_alu_op       (i_alu_op),
    .i_alu_no_stall (i_alu_no_stall),
    .i_reg_dest     (i_reg_dest),
    .i_reg_src1     (i_reg_src1),
    .i_reg_src2     (i_reg_src2),
    .i_field_start  (i_field_start),
    .i_field_last   (i_field_last),
    .i_ins_rtn      (i_ins_rtn),
    .o_run          (),
    .o_prep_go      (prep_go),
    .o_calc_go      (calc_go),
    .o_save_go      (save_go),
    .o_op           (op),
    .o_dest         (dest),
    .o_src1         (src1),
    .o_src2         (src2),
    .o_f_cur        (f_cur),
    .o_first        (first),
    .o_last         (last),
    .o_is_jump      (is_jump),
    .o_stall        (o_alu_stall_dec)
  );

  alu_nibble_calc u_calc (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_prep_go  (prep_go),
    .i_calc_go  (calc_go),
    .i_op       (op),
    .i_first    (first),
    .i_last     (last),
    .i_f_cur    (f_cur),
    .i_src1_nib (src1_nib),
    .i_src2_nib (src2_nib),
    .o_res1     (res1),
    .o_res2     (res2),
    .o_nonzero  (nonzero),
    .o_jump_off (jump_off)
  );

  alu_regfile u_regfile (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_save_go      (save_go),
    .i_op           (op),
    .i_dest         (dest),
    .i_src1         (src1),
    .i_src2         (src2),
    .i_f_cur        (f_cur),
    .i_last         (last),
    .i_imm_value    (i_imm_value),
    .i_res1         (res1),
    .i_res2         (res2),
    .i_nonzero      (nonzero),
    .i_ins_rtn      (i_ins_rtn),
    .i_set_xm       (i_set_xm),
    .i_set_carry    (i_set_carry),
    .i_carry_val    (i_carry_val),
    .i_ins_set_mode (i_ins_set_mode),
    .i_en_alu_save  (i_en_alu_save),
    .i_mode_dec     (i_mode_dec),
    .i_rd_sel       (i_rd_sel),
    .o_src1_nib     (src1_nib),
    .o_src2_nib     (src2_nib),
    .o_reg_p        (o_reg_p),
    .o_carry        (o_carry),
    .o_mode_dec     (o_mode_dec),
    .o_rd_data      (o_rd_data)
  );

  alu_pc_ctrl #(
    .RSTK_DEPTH (RSTK_DEPTH)
  ) u_pc_ctrl (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_en_alu_save (i_en_alu_save),
    .i_prep_go     (prep_go),
    .i_op          (op),
    .i_first       (first),
    .i_last        (last),
    .i_is_jump     (is_jump),
    .i_stall       (o_alu_stall_dec),
    .i_push        (i_push),
    .i_pop         (i_pop),
    .i_jump_off    (jump_off),
    .o_pc          (o_pc)
  );

endmodule

// ==== hdl/saturn_alu_pkg.sv ====
package saturn_alu_pkg;

  // nibble index inside a 64-bit word
  typedef logic [3:0] field_ptr_t;

  // operations run one nibble per prep/calc/save pass
  typedef enum logic [4:0] {
    OP_ZERO     = 5'd0,
    OP_COPY     = 5'd1,
    OP_EXCH     = 5'd2,
    OP_2CMPL    = 5'd3,
    OP_CLR_MASK = 5'd4,
    OP_SET_BIT  = 5'd5,
    OP_RST_BIT  = 5'd6,
    // jumps collect the offset from src1 over the field
    OP_JMP_REL3 = 5'd7,
    OP_JMP_REL4 = 5'd8,
    OP_JMP_ABS5 = 5'd9
  } alu_op_t;

endpackage

// ==== hdl/saturn_regs_pkg.sv ====
package saturn_regs_pkg;

  // one BCD or hex digit
  typedef logic [3:0] nibble_t;

  // 20-bit address, also the width of PC, D0, D1 and return stack entries
  typedef logic [19:0] addr_t;

  // 16-nibble working register (A, B, C, D)
  typedef logic [63:0] word_t;

  // program status bits
  typedef logic [15:0] st_t;

  // register codes used by the decoder for dest, src1, src2 and read-back
  typedef enum logic [4:0] {
    REG_A    = 5'd0,
    REG_B    = 5'd1,
    REG_C    = 5'd2,
    REG_D    = 5'd3,
    REG_D0   = 5'd4,
    REG_D1   = 5'd5,
    REG_ST   = 5'd6,
    REG_P    = 5'd7,
    REG_HST  = 5'd8,
    REG_IMM  = 5'd9,
    REG_ZERO = 5'd10
  } reg_sel_t;

  // XM sits in the lowest HST bit
  localparam int HST_XM = 0;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_saturn_alu -o tb_saturn_alu

out=$(./obj_dir/tb_saturn_alu)
echo "$out"

if echo "$out" | grep -q "^TEST PASS$"; then
  exit 0
fi
exit 1

// ==== src.f ====
+incdir+dv
hdl/saturn_regs_pkg.sv
hdl/saturn_alu_pkg.sv
hdl/alu_sequencer.sv
hdl/alu_nibble_calc.sv
hdl/alu_regfile.sv
hdl/alu_pc_ctrl.sv
hdl/saturn_alu.sv
dv/tb_saturn_alu.sv
